// ==== bench/exec_stim.txt ====
// ctrl, then per lane: flags regs rf1 rf2 imm pc instr exp wdata target etval
// exp: bit0 valid, bit4 jump, bit8 exception, 15:12 ecause, 20:16 rd
0 1000 a0201 5 7 0 100 0 a0001 c 0 0 1001 b0403 3 5 0 104 0 b0001 fffffffe 0 0
0 3002 c0001 3 0 4 108 0 c0001 30 0 0 1003 d0201 ffffffff 1 0 10c 0 d0001 1 0 0
0 1004 e0201 ffffffff 1 0 110 0 e0001 0 0 0 3005 f0001 f0f0f0f0 0 ff 114 0 f0001 f0f0f00f 0 0
0 1006 100201 80000000 4 0 118 0 100001 8000000 0 0 1007 110201 80000000 4 0 11c 0 110001 f8000000 0 0
0 1008 120201 f0 f 0 120 0 120001 ff 0 0 3009 130001 ff00ff00 0 ff0 124 0 130001 f00 0 0
0 300a 140000 0 0 12345000 128 0 140001 12345000 0 0 300b 150000 0 0 1000 200 0 150001 1200 0 0
0 1002 160201 1 21 0 130 0 160001 2 0 0 3003 170001 5 0 fffffff0 134 0 170001 0 0 0
0 1000 50201 100 0 0 140 0 50001 100 0 0 1000 60201 200 0 0 144 0 60001 200 0 0
0 1000 70605 1 1 0 148 0 70001 300 0 0 1000 70006 1 99 0 14c 0 70001 200 0 0
0 1000 80007 55 66 0 150 0 80001 200 0 0 1000 90000 aaaa bbbb 0 154 0 90001 0 0 0
0 1001 a0908 1 2 0 158 0 a0001 200 0 0 1005 b0809 ffff 1 0 15c 0 b0001 200 0 0
0 5000 201 5 6 10 300 0 1 0 0 0 5010 201 5 6 20 304 0 11 0 324 0
0 5020 201 fffffffe 1 fffffff0 400 0 11 0 3f0 0 1000 120201 1 1 0 404 0 0 0 0 0
0 5030 201 fffffffe 1 8 500 0 1 0 0 0 5040 201 1 fffffffe c 504 0 11 0 510 0
0 5050 201 fffffffe 1 40 600 0 11 0 640 0 1000 130201 1 1 0 604 0 0 0 0 0
0 9000 140000 0 0 100 700 0 140011 704 800 0 1000 150201 1 1 0 704 0 0 0 0 0
0 1000 160201 2 3 0 800 0 160001 5 0 0 11000 170001 1000 0 5 804 0 170011 808 1004 0
0 41000 180201 1 1 0 880 deadbeef 182101 0 0 deadbeef 1000 190201 1 1 0 884 0 0 0 0 0
0 181000 1a0000 0 0 0 888 100073 1a3101 0 0 100073 1000 1b0201 1 1 0 88c 0 0 0 0 0
0 c1000 1c0000 0 0 0 890 73 1c2101 0 0 73 1000 1d0201 1 1 0 894 0 0 0 0 0
0 1000 1d0201 1 2 0 898 0 1d0001 3 0 0 81000 1e0000 0 0 0 89c 73 1eb101 0 0 73
0 9000 1f0000 0 0 6 900 6f 1f0101 0 0 906 1000 100201 1 1 0 904 0 0 0 0 0
0 1000 110201 4 4 0 a00 0 110001 8 0 0 5000 201 7 7 2 a04 0 101 0 0 a06
0 21000 120201 fffffff9 2 0 b00 0 120001 fffffffd 0 0 1000 130201 1 1 0 b04 0 130001 2 0 0
0 1000 140201 3 3 0 b08 0 140001 6 0 0 21200 150201 fffffff9 2 0 b0c 0 150001 ffffffff 0 0
0 21100 160201 1234 0 0 b10 0 160001 ffffffff 0 0 1001 170201 10 4 0 b14 0 170001 c 0 0
0 21200 180201 fffffff9 0 0 b18 0 180001 fffffff9 0 0 1000 190201 2 3 0 b1c 0 190001 5 0 0
0 21000 1a0201 80000000 ffffffff 0 b20 0 1a0001 80000000 0 0 1000 1b0201 1 0 0 b24 0 1b0001 1 0 0
0 1005 1c0201 ff f 0 b28 0 1c0001 f0 0 0 21300 1d0201 64 7 0 b2c 0 1d0001 2 0 0
1 1000 1e0201 1 1 0 c00 0 0 0 0 0 1000 1f0201 1 1 0 c04 0 0 0 0 0
5 21000 100201 64 7 0 c08 0 0 0 0 0 1000 110201 1 1 0 c0c 0 0 0 0 0
0 1000 120201 5 6 0 c10 0 120001 b 0 0 21100 130201 64 7 0 c14 0 130001 e 0 0
0 1000 140013 0 0 0 c18 0 140001 e 0 0 1000 151312 1 1 0 c1c 0 150001 19 0 0
ffffffff

// ==== src.f ====
verilog/exec_cfg_pkg.sv
verilog/rv_op_pkg.sv
verilog/operand_forward.sv
verilog/exec_lane.sv
verilog/serial_divider.sv
verilog/result_commit.sv
verilog/exec_top.sv
bench/exec_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module exec_tb -f src.f -o exec_sim > build.log 2>&1 \
  && ./obj_dir/exec_sim > sim.log 2>&1 \
  || { cat build.log; }
[ -f sim.log ] && cat sim.log
grep -q "SIMULATION PASSED" sim.log \
  && echo "run passed" \
  || { echo "run failed"; exit 1; }

// ==== bench/exec_tb.sv ====
`default_nettype none

module exec_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int lanes = exec_cfg_pkg::lane_count;
  localparam int data_width = exec_cfg_pkg::xlen;
  localparam int reg_w = exec_cfg_pkg::reg_addr_width;
  localparam int rec_words = 23; // control word, then 11 words per lane.
  localparam int lane_words = 11;
  localparam int max_lines = 64;

  logic clock = 1'b0;
  logic reset;
  logic clear;
  logic hold;
  logic [lanes-1:0] valid;
  rv_op_pkg::alu_op_t [lanes-1:0] alu_op;
  rv_op_pkg::br_op_t [lanes-1:0] br_op;
  rv_op_pkg::div_op_t [lanes-1:0] div_op;
  logic [lanes-1:0] use_imm;
  logic [lanes-1:0] is_branch;
  logic [lanes-1:0] is_jal;
  logic [lanes-1:0] is_jalr;
  logic [lanes-1:0] is_div;
  logic [lanes-1:0] is_illegal;
  logic [lanes-1:0] is_ecall;
  logic [lanes-1:0] is_ebreak;
  logic [lanes-1:0][reg_w-1:0] rs1;
  logic [lanes-1:0][reg_w-1:0] rs2;
  logic [lanes-1:0][reg_w-1:0] rd;
  logic [lanes-1:0][data_width-1:0] rf_data1;
  logic [lanes-1:0][data_width-1:0] rf_data2;
  logic [lanes-1:0][data_width-1:0] imm;
  logic [lanes-1:0][data_width-1:0] pc;
  logic [lanes-1:0][31:0] instr;
  logic [lanes-1:0] out_valid;
  logic [lanes-1:0][reg_w-1:0] out_rd;
  logic [lanes-1:0][data_width-1:0] out_wdata;
  logic [lanes-1:0] out_jump;
  logic [lanes-1:0][data_width-1:0] out_target;
  logic [lanes-1:0] out_exception;
  rv_op_pkg::ecause_t [lanes-1:0] out_ecause;
  logic [lanes-1:0][data_width-1:0] out_etval;
  logic stall;

  logic [31:0] stim_mem [0:max_lines*rec_words-1];
  logic [15:0] lfsr_state;
  int line_count;
  int cycle_count = 0;
  int cycle_limit = 0;
  int value_errors = 0;
  int bubble_errors = 0;

  exec_top #(.data_width(data_width), .lanes(lanes)) uut (
    .clock(clock), .reset(reset), .clear(clear), .hold(hold), .valid(valid),
    .alu_op(alu_op), .br_op(br_op), .div_op(div_op), .use_imm(use_imm),
    .is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr), .is_div(is_div),
    .is_illegal(is_illegal), .is_ecall(is_ecall), .is_ebreak(is_ebreak),
    .rs1(rs1), .rs2(rs2), .rd(rd), .rf_data1(rf_data1), .rf_data2(rf_data2),
    .imm(imm), .pc(pc), .instr(instr), .out_valid(out_valid), .out_rd(out_rd),
    .out_wdata(out_wdata), .out_jump(out_jump), .out_target(out_target),
    .out_exception(out_exception), .out_ecause(out_ecause), .out_etval(out_etval),
    .stall(stall)
  );

  always #10 clock = ~clock;

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout after %0d cycles without finishing the stimulus", cycle_count);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // galois lfsr with taps 16, 14, 13 and 11.
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic [15:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ 16'hb400;
    end
    return next;
  endfunction

  task automatic random_bit(output logic bit_out);
    bit_out = lfsr_state[0];
    lfsr_state = lfsr_next(lfsr_state);
  endtask

  task automatic idle_inputs();
    clear = 1'b0;
    hold = 1'b0;
    for (int i = 0; i < lanes; i++) begin
      valid[i] = 1'b0;
      alu_op[i] = rv_op_pkg::alu_add;
      br_op[i] = rv_op_pkg::br_beq;
      div_op[i] = rv_op_pkg::div_div;
      {use_imm[i], is_branch[i], is_jal[i], is_jalr[i]} = 4'b0;
      {is_div[i], is_illegal[i], is_ecall[i], is_ebreak[i]} = 4'b0;
      rs1[i] = '0;
      rs2[i] = '0;
      rd[i] = '0;
      rf_data1[i] = '0;
      rf_data2[i] = '0;
      imm[i] = '0;
      pc[i] = '0;
      instr[i] = '0;
    end
  endtask

  task automatic load_pair(input int idx);
    int base;
    logic [31:0] f;
    logic [31:0] r;
    for (int i = 0; i < lanes; i++) begin
      base = idx * rec_words + 1 + i * lane_words;
      f = stim_mem[base];
      r = stim_mem[base+1];
      alu_op[i] = rv_op_pkg::alu_op_t'(f[3:0]);
      br_op[i] = rv_op_pkg::br_op_t'(f[6:4]);
      div_op[i] = rv_op_pkg::div_op_t'(f[9:8]);
      {is_jal[i], is_branch[i], use_imm[i], valid[i]} = f[15:12];
      {is_ecall[i], is_illegal[i], is_div[i], is_jalr[i]} = f[19:16];
      is_ebreak[i] = f[20];
      rs1[i] = r[4:0];
      rs2[i] = r[12:8];
      rd[i] = r[20:16];
      rf_data1[i] = stim_mem[base+2];
      rf_data2[i] = stim_mem[base+3];
      imm[i] = stim_mem[base+4];
      pc[i] = stim_mem[base+5];
      instr[i] = stim_mem[base+6];
    end
  endtask

  // the control word names the cycle of the pair on which clear is pulsed.
  task automatic set_controls(input int idx, input int cyc);
    logic a;
    logic b;
    clear = stim_mem[idx*rec_words] == 32'(cyc);
    random_bit(a);
    random_bit(b);
    hold = a & b;
  endtask

  task automatic check_value(input string name, input int lane, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERR %s[%0d] got %h expected %h", name, lane, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_bubble();
    assert (out_valid == '0 && out_jump == '0 && out_exception == '0) else begin
      $display("ERR bubble out_valid %h out_jump %h out_exception %h expected 0",
               out_valid, out_jump, out_exception);
      bubble_errors++;
    end
  endtask

  task automatic check_pair(input int idx);
    int base;
    logic [31:0] e;
    for (int i = 0; i < lanes; i++) begin
      base = idx * rec_words + 1 + i * lane_words;
      e = stim_mem[base+7];
      check_value("out_valid", i, 32'(out_valid[i]), 32'(e[0]));
      check_value("out_jump", i, 32'(out_jump[i]), 32'(e[4]));
      check_value("out_exception", i, 32'(out_exception[i]), 32'(e[8]));
      if (e[0]) begin
        check_value("out_rd", i, 32'(out_rd[i]), 32'(e[20:16]));
        if (!e[8] && e[20:16] != 5'd0) begin
          check_value("out_wdata", i, out_wdata[i], stim_mem[base+8]);
        end
        if (e[4]) begin
          check_value("out_target", i, out_target[i], stim_mem[base+9]);
        end
        if (e[8]) begin
          check_value("out_ecause", i, 32'(out_ecause[i]), 32'(e[15:12]));
          check_value("out_etval", i, out_etval[i], stim_mem[base+10]);
        end
      end
    end
  endtask

  // a committed divide stalls for every divider step plus the ready cycle.
  function automatic int divide_stall(input int idx);
    int base;
    int cycles;
    logic [31:0] f;
    logic [31:0] e;
    cycles = 0;
    for (int i = 0; i < lanes; i++) begin
      base = idx * rec_words + 1 + i * lane_words;
      f = stim_mem[base];
      e = stim_mem[base+7];
      if (f[17] && e[0]) begin
        cycles = exec_cfg_pkg::div_steps + 1;
      end
    end
    return cycles;
  endfunction

  initial begin
    logic finish;
    int stall_cycles;
    reset = 1'b0;
    idle_inputs();
    lfsr_state = 16'd22625;
    $readmemh("bench/exec_stim.txt", stim_mem);
    line_count = 0;
    while (line_count < max_lines && stim_mem[line_count*rec_words] != 32'hffffffff) begin
      line_count++;
    end
    if (line_count == 0 || line_count == max_lines) begin
      $display("stimulus file is missing or has no end marker");
      $display("SIMULATION FAILED");
      $finish;
    end else begin
      cycle_limit = line_count * (exec_cfg_pkg::div_steps + 4) + 100 + 8;
      repeat (8) @(posedge clock);
      #1;
      check_bubble();
      check_value("stall", 0, 32'(stall), 32'd0);
      #1;
      reset = 1'b1;
      for (int idx = 0; idx < line_count; idx++) begin
        load_pair(idx);
        set_controls(idx, 1);
        stall_cycles = 0;
        for (int cyc = 2; cyc > 0; cyc++) begin
          @(negedge clock);
          finish = clear || (!stall && !hold); // the pair leaves on this edge.
          if (stall) begin
            stall_cycles++;
          end
          @(posedge clock);
          #1;
          if (finish) begin
            check_pair(idx);
            if (!clear) begin
              check_value("stall_cycles", 0, 32'(stall_cycles), 32'(divide_stall(idx)));
            end
          end else begin
            check_bubble();
          end
          #1;
          if (finish) begin
            break;
          end
          set_controls(idx, cyc);
        end
      end
      idle_inputs();
      $display("errors: value %0d, bubble %0d", value_errors, bubble_errors);
      if (value_errors + bubble_errors == 0) begin
        $display("SIMULATION PASSED");
      end else begin
        $display("SIMULATION FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/exec_top.sv ====
`default_nettype none

module exec_top #(
  parameter int data_width = exec_cfg_pkg::xlen,
  parameter int lanes = exec_cfg_pkg::lane_count
) (
  input logic clock,
  input logic reset,
  input logic clear,
  input logic hold,
  input logic [lanes-1:0] valid,
  input rv_op_pkg::alu_op_t [lanes-1:0] alu_op,
  input rv_op_pkg::br_op_t [lanes-1:0] br_op,
  input rv_op_pkg::div_op_t [lanes-1:0] div_op,
  input logic [lanes-1:0] use_imm,
  input logic [lanes-1:0] is_branch,
  input logic [lanes-1:0] is_jal,
  input logic [lanes-1:0] is_jalr,
  input logic [lanes-1:0] is_div,
  input logic [lanes-1:0] is_illegal,
  input logic [lanes-1:0] is_ecall,
  input logic [lanes-1:0] is_ebreak,
  input logic [lanes-1:0][exec_cfg_pkg::reg_addr_width-1:0] rs1,
  input logic [lanes-1:0][exec_cfg_pkg::reg_addr_width-1:0] rs2,
  input logic [lanes-1:0][exec_cfg_pkg::reg_addr_width-1:0] rd,
  input logic [lanes-1:0][data_width-1:0] rf_data1,
  input logic [lanes-1:0][data_width-1:0] rf_data2,
  input logic [lanes-1:0][data_width-1:0] imm,
  input logic [lanes-1:0][data_width-1:0] pc,
  input logic [lanes-1:0][31:0] instr,
  output logic [lanes-1:0] out_valid,
  output logic [lanes-1:0][exec_cfg_pkg::reg_addr_width-1:0] out_rd,
  output logic [lanes-1:0][data_width-1:0] out_wdata,
  output logic [lanes-1:0] out_jump,
  output logic [lanes-1:0][data_width-1:0] out_target,
  output logic [lanes-1:0] out_exception,
  output rv_op_pkg::ecause_t [lanes-1:0] out_ecause,
  output logic [lanes-1:0][data_width-1:0] out_etval,
  output logic stall
);

  logic [lanes-1:0][data_width-1:0] op_a;
  logic [lanes-1:0][data_width-1:0] op_b;
  logic [lanes-1:0][data_width-1:0] lane_result;
  logic [lanes-1:0] jump;
  logic [lanes-1:0][data_width-1:0] target;
  logic [lanes-1:0] exception;
  rv_op_pkg::ecause_t [lanes-1:0] ecause;
  logic [lanes-1:0][data_width-1:0] etval;
  logic [lanes-1:0] wb_valid;
  logic [lanes-1:0] wb_kill;
  logic div_start;
  logic div_ready;
  logic [data_width-1:0] div_result;
  logic [data_width-1:0] div_dividend;
  logic [data_width-1:0] div_divisor;
  rv_op_pkg::div_op_t div_kind;

  operand_forward #(.data_width(data_width), .lanes(lanes)) u_forward (
    .rs1(rs1),
    .rs2(rs2),
    .rf_data1(rf_data1),
    .rf_data2(rf_data2),
    .wb_valid(wb_valid),
    .wb_rd(out_rd),
    .wb_wdata(out_wdata),
    .wb_kill(wb_kill),
    .op_a(op_a),
    .op_b(op_b)
  );

  for (genvar i = 0; i < lanes; i++) begin : g_lane
    exec_lane #(.data_width(data_width)) u_lane (
      .op_a(op_a[i]),
      .op_b(op_b[i]),
      .imm(imm[i]),
      .pc(pc[i]),
      .instr(instr[i]),
      .alu_op(alu_op[i]),
      .br_op(br_op[i]),
      .use_imm(use_imm[i]),
      .is_branch(is_branch[i]),
      .is_jal(is_jal[i]),
      .is_jalr(is_jalr[i]),
      .is_illegal(is_illegal[i]),
      .is_ecall(is_ecall[i]),
      .is_ebreak(is_ebreak[i]),
      .result(lane_result[i]),
      .jump(jump[i]),
      .target(target[i]),
      .exception(exception[i]),
      .ecause(ecause[i]),
      .etval(etval[i])
    );
  end

  serial_divider #(.data_width(data_width)) u_divider (
    .clock(clock),
    .reset(reset),
    .start(div_start),
    .cancel(clear),
    .div_op(div_kind),
    .dividend(div_dividend),
    .divisor(div_divisor),
    .ready(div_ready),
    .result(div_result)
  );

  result_commit #(.data_width(data_width), .lanes(lanes)) u_commit (
    .clock(clock),
    .reset(reset),
    .clear(clear),
    .hold(hold),
    .valid(valid),
    .is_div(is_div),
    .div_op(div_op),
    .op_a(op_a),
    .op_b(op_b),
    .rd(rd),
    .lane_result(lane_result),
    .jump(jump),
    .target(target),
    .exception(exception),
    .ecause(ecause),
    .etval(etval),
    .div_ready(div_ready),
    .div_result(div_result),
    .out_valid(out_valid),
    .out_rd(out_rd),
    .out_wdata(out_wdata),
    .out_jump(out_jump),
    .out_target(out_target),
    .out_exception(out_exception),
    .out_ecause(out_ecause),
    .out_etval(out_etval),
    .wb_valid(wb_valid),
    .wb_kill(wb_kill),
    .div_start(div_start),
    .div_dividend(div_dividend),
    .div_divisor(div_divisor),
    .div_kind(div_kind),
    .stall(stall)
  );

endmodule

`default_nettype wire

// ==== verilog/result_commit.sv ====
`default_nettype none

module result_commit #(
  parameter int data_width = 32,
  parameter int lanes = 2
) (
  input logic clock,
  input logic reset,
  input logic clear,
  input logic hold,
  input logic [lanes-1:0] valid,
  input logic [lanes-1:0] is_div,
  input rv_op_pkg::div_op_t [lanes-1:0] div_op,
  input logic [lanes-1:0][data_width-1:0] op_a,
  input logic [lanes-1:0][data_width-1:0] op_b,
  input logic [lanes-1:0][exec_cfg_pkg::reg_addr_width-1:0] rd,
  input logic [lanes-1:0][data_width-1:0] lane_result,
  input logic [lanes-1:0] jump,
  input logic [lanes-1:0][data_width-1:0] target,
  input logic [lanes-1:0] exception,
  input rv_op_pkg::ecause_t [lanes-1:0] ecause,
  input logic [lanes-1:0][data_width-1:0] etval,
  input logic div_ready,
  input logic [data_width-1:0] div_result,
  output logic [lanes-1:0] out_valid,
  output logic [lanes-1:0][exec_cfg_pkg::reg_addr_width-1:0] out_rd,
  output logic [lanes-1:0][data_width-1:0] out_wdata,
  output logic [lanes-1:0] out_jump,
  output logic [lanes-1:0][data_width-1:0] out_target,
  output logic [lanes-1:0] out_exception,
  output rv_op_pkg::ecause_t [lanes-1:0] out_ecause,
  output logic [lanes-1:0][data_width-1:0] out_etval,
  output logic [lanes-1:0] wb_valid,
  output logic [lanes-1:0] wb_kill,
  output logic div_start,
  output logic [data_width-1:0] div_dividend,
  output logic [data_width-1:0] div_divisor,
  output rv_op_pkg::div_op_t div_kind,
  output logic stall
);

  logic [lanes-1:0] keep;
  logic [lanes-1:0] valid_q;
  logic [lanes-1:0] jump_q;
  logic [lanes-1:0] exc_q;
  logic live; // last edge wrote a real entry, not a bubble.
  logic div_pending;
  logic div_busy;
  logic div_have;
  logic [data_width-1:0] div_saved;
  logic [data_width-1:0] div_data;
  logic advance;

  // a redirecting slot kills every younger slot behind it.
  always_comb begin
    logic redirect;
    redirect = 1'b0;
    div_pending = 1'b0;
    div_dividend = op_a[0];
    div_divisor = op_b[0];
    div_kind = div_op[0];
    for (int i = 0; i < lanes; i++) begin
      keep[i] = valid[i] & ~redirect;
      redirect = redirect | (keep[i] & (jump[i] | exception[i]));
      if (keep[i] && is_div[i]) begin
        div_pending = 1'b1;
        div_dividend = op_a[i];
        div_divisor = op_b[i];
        div_kind = div_op[i];
      end
    end
  end

  assign div_data = div_have ? div_saved : div_result;
  assign stall = div_pending & ~div_ready & ~div_have & ~clear;
  assign div_start = div_pending & ~div_busy & ~div_have & ~clear;
  assign advance = ~stall & ~hold;

  always_ff @(posedge clock) begin
    if (reset == 1'b0 || clear) begin
      valid_q <= '0;
      jump_q <= '0;
      exc_q <= '0;
      live <= 1'b0;
      div_busy <= 1'b0;
      div_have <= 1'b0;
    end else begin
      live <= advance;
      if (div_start) begin
        div_busy <= 1'b1;
      end else if (div_ready) begin
        div_busy <= 1'b0;
      end
      if (advance) begin
        valid_q <= keep;
        jump_q <= keep & jump;
        exc_q <= keep & exception;
        div_have <= 1'b0;
      end else if (div_ready) begin
        div_have <= 1'b1; // quotient arrived under hold, park it.
      end
    end
  end

  // the payload holds through bubbles so forwarding still sees the last commit.
  always_ff @(posedge clock) begin
    if (advance) begin
      out_rd <= rd;
      out_target <= target;
      out_ecause <= ecause;
      out_etval <= etval;
      for (int i = 0; i < lanes; i++) begin
        out_wdata[i] <= is_div[i] ? div_data : lane_result[i];
      end
    end
    if (div_ready && !advance) begin
      div_saved <= div_result;
    end
  end

  assign out_valid = valid_q & {lanes{live}};
  assign out_jump = jump_q & {lanes{live}};
  assign out_exception = exc_q & {lanes{live}};
  assign wb_valid = valid_q;
  assign wb_kill = exc_q;

endmodule

`default_nettype wire

// ==== verilog/serial_divider.sv ====
`default_nettype none

module serial_divider #(
  parameter int data_width = 32
) (
  input logic clock,
  input logic reset,
  input logic start,
  input logic cancel,
  input rv_op_pkg::div_op_t div_op,
  input logic [data_width-1:0] dividend,
  input logic [data_width-1:0] divisor,
  output logic ready,
  output logic [data_width-1:0] result
);

  localparam int count_width = $clog2(data_width + 1);

  logic busy;
  logic done;
  logic [count_width-1:0] count;
  logic [data_width-1:0] rem;
  logic [data_width-1:0] quo;
  logic [data_width-1:0] dsor;
  logic neg_quo;
  logic neg_rem;
  logic want_rem;
  logic signed_op;
  logic [data_width-1:0] abs_dividend;
  logic [data_width-1:0] abs_divisor;
  logic [data_width:0] trial;

  assign signed_op = div_op == rv_op_pkg::div_div || div_op == rv_op_pkg::div_rem;
  assign abs_dividend = (signed_op && dividend[data_width-1]) ? -dividend : dividend;
  assign abs_divisor = (signed_op && divisor[data_width-1]) ? -divisor : divisor;
  assign trial = {rem, quo[data_width-1]} - {1'b0, dsor}; // top bit set means no fit.

  always_ff @(posedge clock) begin
    if (reset == 1'b0 || cancel) begin
      busy <= 1'b0;
      done <= 1'b0;
    end else if (start) begin
      busy <= 1'b1;
      done <= 1'b0;
    end else if (busy && count == count_width'(1)) begin
      busy <= 1'b0;
      done <= 1'b1;
    end else begin
      done <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      count <= count_width'(data_width);
      rem <= '0;
      quo <= abs_dividend;
      dsor <= abs_divisor;
      // a zero divisor keeps the all ones quotient whatever the signs.
      neg_quo <= signed_op & (dividend[data_width-1] ^ divisor[data_width-1]) & (|divisor);
      neg_rem <= signed_op & dividend[data_width-1];
      want_rem <= div_op == rv_op_pkg::div_rem || div_op == rv_op_pkg::div_remu;
    end else if (busy) begin
      count <= count - count_width'(1);
      if (!trial[data_width]) begin
        rem <= trial[data_width-1:0];
        quo <= {quo[data_width-2:0], 1'b1};
      end else begin
        rem <= {rem[data_width-2:0], quo[data_width-1]};
        quo <= {quo[data_width-2:0], 1'b0};
      end
    end
  end

  assign ready = done;
  assign result = want_rem ? (neg_rem ? -rem : rem) : (neg_quo ? -quo : quo);

endmodule

`default_nettype wire

// ==== verilog/exec_lane.sv ====
`default_nettype none

module exec_lane #(
  parameter int data_width = 32
) (
  input logic [data_width-1:0] op_a,
  input logic [data_width-1:0] op_b,
  input logic [data_width-1:0] imm,
  input logic [data_width-1:0] pc,
  input logic [31:0] instr,
  input rv_op_pkg::alu_op_t alu_op,
  input rv_op_pkg::br_op_t br_op,
  input logic use_imm,
  input logic is_branch,
  input logic is_jal,
  input logic is_jalr,
  input logic is_illegal,
  input logic is_ecall,
  input logic is_ebreak,
  output logic [data_width-1:0] result,
  output logic jump,
  output logic [data_width-1:0] target,
  output logic exception,
  output rv_op_pkg::ecause_t ecause,
  output logic [data_width-1:0] etval
);

  localparam int shamt_width = $clog2(data_width);

  logic [data_width-1:0] src_b;
  logic [shamt_width-1:0] shamt;
  logic [data_width-1:0] alu_out;
  logic [data_width-1:0] link;
  logic cond;
  logic redirect;

  assign src_b = use_imm ? imm : op_b;
  assign shamt = src_b[shamt_width-1:0];
  assign link = pc + data_width'(4); // return address for jal and jalr.

  always_comb begin
    case (alu_op)
      rv_op_pkg::alu_add:   alu_out = op_a + src_b;
      rv_op_pkg::alu_sub:   alu_out = op_a - src_b;
      rv_op_pkg::alu_sll:   alu_out = op_a << shamt;
      rv_op_pkg::alu_slt:   alu_out = data_width'($signed(op_a) < $signed(src_b));
      rv_op_pkg::alu_sltu:  alu_out = data_width'(op_a < src_b);
      rv_op_pkg::alu_xor:   alu_out = op_a ^ src_b;
      rv_op_pkg::alu_srl:   alu_out = op_a >> shamt;
      rv_op_pkg::alu_sra:   alu_out = $unsigned($signed(op_a) >>> shamt);
      rv_op_pkg::alu_or:    alu_out = op_a | src_b;
      rv_op_pkg::alu_and:   alu_out = op_a & src_b;
      rv_op_pkg::alu_lui:   alu_out = imm;
      rv_op_pkg::alu_auipc: alu_out = pc + imm;
      default:              alu_out = '0;
    endcase
  end

  // branches always compare the two registers, never the immediate.
  always_comb begin
    case (br_op)
      rv_op_pkg::br_beq:  cond = op_a == op_b;
      rv_op_pkg::br_bne:  cond = op_a != op_b;
      rv_op_pkg::br_blt:  cond = $signed(op_a) < $signed(op_b);
      rv_op_pkg::br_bge:  cond = $signed(op_a) >= $signed(op_b);
      rv_op_pkg::br_bltu: cond = op_a < op_b;
      rv_op_pkg::br_bgeu: cond = op_a >= op_b;
      default:            cond = 1'b0;
    endcase
  end

  assign result = (is_jal | is_jalr) ? link : alu_out;
  assign target = is_jalr ? ((op_a + imm) & ~data_width'(1)) : pc + imm;
  assign redirect = is_jal | is_jalr | (is_branch & cond);

  always_comb begin
    exception = 1'b1;
    ecause = rv_op_pkg::cause_none;
    etval = data_width'(instr);
    if (is_illegal) begin
      ecause = rv_op_pkg::cause_illegal_instr;
    end else if (is_ebreak) begin
      ecause = rv_op_pkg::cause_breakpoint;
    end else if (is_ecall) begin
      ecause = rv_op_pkg::cause_ecall_m;
    end else if (redirect && target[1]) begin
      ecause = rv_op_pkg::cause_misaligned_fetch; // no compressed instructions here.
      etval = target;
    end else begin
      exception = 1'b0;
      etval = '0;
    end
  end

  assign jump = redirect & ~exception;

endmodule

`default_nettype wire

// ==== verilog/operand_forward.sv ====
`default_nettype none

module operand_forward #(
  parameter int data_width = 32,
  parameter int lanes = 2
) (
  input logic [lanes-1:0][exec_cfg_pkg::reg_addr_width-1:0] rs1,
  input logic [lanes-1:0][exec_cfg_pkg::reg_addr_width-1:0] rs2,
  input logic [lanes-1:0][data_width-1:0] rf_data1,
  input logic [lanes-1:0][data_width-1:0] rf_data2,
  input logic [lanes-1:0] wb_valid,
  input logic [lanes-1:0][exec_cfg_pkg::reg_addr_width-1:0] wb_rd,
  input logic [lanes-1:0][data_width-1:0] wb_wdata,
  input logic [lanes-1:0] wb_kill,
  output logic [lanes-1:0][data_width-1:0] op_a,
  output logic [lanes-1:0][data_width-1:0] op_b
);

  logic [lanes-1:0] wb_live;

  // an entry forwards only if it really writes a register.
  always_comb begin
    for (int w = 0; w < lanes; w++) begin
      wb_live[w] = wb_valid[w] & ~wb_kill[w] & (wb_rd[w] != '0);
    end
  end

  // higher lanes are younger, so a later match overrides an earlier one.
  function automatic logic [data_width-1:0] newest(
    input logic [exec_cfg_pkg::reg_addr_width-1:0] addr,
    input logic [data_width-1:0] stale
  );
    logic [data_width-1:0] value;
    value = stale;
    for (int w = 0; w < lanes; w++) begin
      if (wb_live[w] && wb_rd[w] == addr) begin
        value = wb_wdata[w];
      end
    end
    if (addr == '0) begin
      value = '0; // x0 is hardwired.
    end
    return value;
  endfunction

  always_comb begin
    for (int s = 0; s < lanes; s++) begin
      op_a[s] = newest(rs1[s], rf_data1[s]);
      op_b[s] = newest(rs2[s], rf_data2[s]);
    end
  end

endmodule

`default_nettype wire

// ==== verilog/rv_op_pkg.sv ====
`default_nettype none

package rv_op_pkg;

  typedef enum logic [3:0] {
    alu_add   = 4'd0,
    alu_sub   = 4'd1,
    alu_sll   = 4'd2,
    alu_slt   = 4'd3,
    alu_sltu  = 4'd4,
    alu_xor   = 4'd5,
    alu_srl   = 4'd6,
    alu_sra   = 4'd7,
    alu_or    = 4'd8,
    alu_and   = 4'd9,
    alu_lui   = 4'd10,
    alu_auipc = 4'd11
  } alu_op_t;

  typedef enum logic [2:0] {
    br_beq  = 3'd0,
    br_bne  = 3'd1,
    br_blt  = 3'd2,
    br_bge  = 3'd3,
    br_bltu = 3'd4,
    br_bgeu = 3'd5
  } br_op_t;

  typedef enum logic [1:0] {
    div_div  = 2'd0,
    div_divu = 2'd1,
    div_rem  = 2'd2,
    div_remu = 2'd3
  } div_op_t;

  // machine cause codes; a misaligned target shares code 0 with no exception.
  typedef logic [3:0] ecause_t;
  localparam ecause_t cause_none = 4'd0;
  localparam ecause_t cause_misaligned_fetch = 4'd0;
  localparam ecause_t cause_illegal_instr = 4'd2;
  localparam ecause_t cause_breakpoint = 4'd3;
  localparam ecause_t cause_ecall_m = 4'd11;

endpackage

`default_nettype wire

// ==== verilog/exec_cfg_pkg.sv ====
`default_nettype none

package exec_cfg_pkg;

  // integer data path width of the execute stage.
  localparam int xlen = 32;

  localparam int reg_addr_width = 5; // x0 to x31.

  // instruction slots issued together each cycle.
  localparam int lane_count = 2;

  // the divider retires one quotient bit per step.
  localparam int div_steps = xlen;

endpackage

`default_nettype wire
